// ==== Makefile ====
# Verilator simulation of the asynchronous FIFO
# Any variable can be overridden on the command line

VERILATOR ?= verilator
TOP ?= cdc_fifo_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || { cat $(LOG); exit 1; }
	cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
hdl/cdc_fifo_cfg_pkg.sv
hdl/cdc_fifo_types_pkg.sv
hdl/cdc_fifo_write_service.sv
hdl/cdc_pointer_sync.sv
hdl/cdc_fifo_memory.sv
hdl/cdc_fifo_read_service.sv
hdl/cdc_fifo.sv
sim/cdc_fifo_checker.sv
sim/cdc_fifo_tb.sv

// ==== hdl/cdc_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo (
    // Write domain
    input wire rx_aclk,
    input wire rx_areset_n,
    input wire rx_tvalid,
    input wire [cdc_fifo_cfg_pkg::data_width-1:0] rx_tdata,
    output logic rx_tready,
    // Read domain
    input wire tx_aclk,
    input wire tx_areset_n,
    output logic tx_tvalid,
    output logic [cdc_fifo_cfg_pkg::data_width-1:0] tx_tdata,
    input wire tx_tready
);
    import cdc_fifo_cfg_pkg::*;
    import cdc_fifo_types_pkg::*;

    // Write request from rx service to storage
    mem_write_t mem_write;
    // Pointers in their own domain
    pointer_bundle_t home_pointer;
    // Same pointers after crossing to the opposite domain
    pointer_bundle_t synced_pointer;
    // Asynchronous read port
    logic [address_width-1:0] read_address;
    logic [data_width-1:0] read_data;

    // Accepts rx beats, throttles with rx_tready
    cdc_fifo_write_service i_write_service (
        .rx_aclk(rx_aclk),
        .rx_areset_n(rx_areset_n),
        .rx_tvalid(rx_tvalid),
        .rx_tdata(rx_tdata),
        .rx_tready(rx_tready),
        .mem_write(mem_write),
        .write_pointer(home_pointer.write_pointer),
        .read_pointer_synced(synced_pointer.read_pointer)
    );

    // Write pointer, rx to tx
    cdc_pointer_sync i_write_pointer_sync (
        .source_aclk(rx_aclk),
        .source_areset_n(rx_areset_n),
        .source_pointer(home_pointer.write_pointer),
        .dest_aclk(tx_aclk),
        .dest_areset_n(tx_areset_n),
        .dest_pointer(synced_pointer.write_pointer)
    );

    // Read pointer, tx to rx
    cdc_pointer_sync i_read_pointer_sync (
        .source_aclk(tx_aclk),
        .source_areset_n(tx_areset_n),
        .source_pointer(home_pointer.read_pointer),
        .dest_aclk(rx_aclk),
        .dest_areset_n(rx_areset_n),
        .dest_pointer(synced_pointer.read_pointer)
    );

    cdc_fifo_memory i_memory (
        .rx_aclk(rx_aclk),
        .mem_write(mem_write),
        .read_address(read_address),
        .read_data(read_data)
    );

    // Presents words on tx, holds them under back-pressure
    cdc_fifo_read_service i_read_service (
        .tx_aclk(tx_aclk),
        .tx_areset_n(tx_areset_n),
        .write_pointer_synced(synced_pointer.write_pointer),
        .read_data(read_data),
        .read_address(read_address),
        .read_pointer(home_pointer.read_pointer),
        .tx_tvalid(tx_tvalid),
        .tx_tdata(tx_tdata),
        .tx_tready(tx_tready)
    );

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo_cfg_pkg.sv ====
`default_nettype none

package cdc_fifo_cfg_pkg;

    // Bits carried by one stream word
    localparam int unsigned data_width = 16;

    // Pointer and memory address bits
    // Pointers wrap at the storage depth
    localparam int unsigned address_width = 4;

    // Storage entries, one per address
    localparam int unsigned fifo_depth = 2 ** address_width;

    // Fill level at or above which rx_tready drops
    // Three entries stay free for beats that slip past the registered ready
    localparam int unsigned almost_full = fifo_depth - 3;

    // Flip-flops in each synchronizer chain on the destination side
    localparam int unsigned sync_stages = 2;

endpackage

`default_nettype wire

// ==== hdl/cdc_fifo_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_memory (
    // Write side, rx domain
    input wire rx_aclk,
    input wire cdc_fifo_types_pkg::mem_write_t mem_write,
    // Read side, tx domain
    input wire [cdc_fifo_cfg_pkg::address_width-1:0] read_address,
    output logic [cdc_fifo_cfg_pkg::data_width-1:0] read_data
);
    import cdc_fifo_cfg_pkg::*;

    // Register file, one word per pointer value
    logic [data_width-1:0] storage [fifo_depth];

    // Written only from the rx clock
    always_ff @(posedge rx_aclk) begin
        if (mem_write.enable) begin
            storage[mem_write.address] <= mem_write.data;
        end
    end

    // Asynchronous read
    // The slot is stable long before the crossed write pointer exposes it
    assign read_data = storage[read_address];

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo_read_service.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_read_service (
    input wire tx_aclk,
    input wire tx_areset_n,
    // Write pointer after crossing into tx
    input wire [cdc_fifo_cfg_pkg::address_width-1:0] write_pointer_synced,
    // Storage read port
    input wire [cdc_fifo_cfg_pkg::data_width-1:0] read_data,
    output logic [cdc_fifo_cfg_pkg::address_width-1:0] read_address,
    output logic [cdc_fifo_cfg_pkg::address_width-1:0] read_pointer,
    // Outgoing stream
    output logic tx_tvalid,
    output logic [cdc_fifo_cfg_pkg::data_width-1:0] tx_tdata,
    input wire tx_tready
);
    import cdc_fifo_cfg_pkg::*;

    // At least one stored word not yet loaded
    logic not_empty;
    // Output register empty, or its word leaves on this edge
    logic output_free;
    // Take the word at the read pointer this edge
    logic load;
    logic [address_width-1:0] read_pointer_next;

    // Crossed pointer is conservative, it never runs ahead of storage
    assign not_empty = (write_pointer_synced != read_pointer);
    assign output_free = !tx_tvalid || tx_tready;
    assign load = not_empty && output_free;

    assign read_pointer_next = read_pointer + address_width'(load);

    // Storage is addressed straight from the pointer
    assign read_address = read_pointer;

    // Advances once per loaded word
    always_ff @(posedge tx_aclk or negedge tx_areset_n) begin
        if (!tx_areset_n) begin
            read_pointer <= '0;
        end else begin
            read_pointer <= read_pointer_next;
        end
    end

    // Valid holds until the transfer
    // refills right away when another word is waiting
    always_ff @(posedge tx_aclk or negedge tx_areset_n) begin
        if (!tx_areset_n) begin
            tx_tvalid <= 1'b0;
        end else if (output_free) begin
            tx_tvalid <= not_empty;
        end
    end

    // Output word
    // Loads only when the register is free
    always_ff @(posedge tx_aclk) begin
        if (load) begin
            tx_tdata <= read_data;
        end
    end

    // A stalled word stays put until the sink takes it
    assert property (@(posedge tx_aclk) disable iff (!tx_areset_n)
        tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata));

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo_types_pkg.sv ====
`default_nettype none

package cdc_fifo_types_pkg;

    // One write into FIFO storage, issued in the rx domain
    typedef struct packed {
        // Store the word on the next rx edge
        logic enable;
        // Slot taken from the write pointer
        logic [cdc_fifo_cfg_pkg::address_width-1:0] address;
        // Word captured from rx_tdata
        logic [cdc_fifo_cfg_pkg::data_width-1:0] data;
    } mem_write_t;

    // Both binary pointers of the FIFO
    // Used once for the home-domain values and once for the crossed copies
    typedef struct packed {
        // Advances as words land in storage
        logic [cdc_fifo_cfg_pkg::address_width-1:0] write_pointer;
        // Advances as words load into the tx output register
        logic [cdc_fifo_cfg_pkg::address_width-1:0] read_pointer;
    } pointer_bundle_t;

endpackage

`default_nettype wire

// ==== hdl/cdc_fifo_write_service.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_write_service (
    input wire rx_aclk,
    input wire rx_areset_n,
    // Incoming stream
    input wire rx_tvalid,
    input wire [cdc_fifo_cfg_pkg::data_width-1:0] rx_tdata,
    output logic rx_tready,
    // Write request toward storage
    output cdc_fifo_types_pkg::mem_write_t mem_write,
    output logic [cdc_fifo_cfg_pkg::address_width-1:0] write_pointer,
    // Read pointer after crossing into rx
    input wire [cdc_fifo_cfg_pkg::address_width-1:0] read_pointer_synced
);
    import cdc_fifo_cfg_pkg::*;

    // Beat taken on the previous edge
    logic beat_valid;
    logic [data_width-1:0] beat_data;
    // Pointer after the pending write lands
    logic [address_width-1:0] write_pointer_next;
    // Registered occupancy seen from the rx side
    logic [address_width-1:0] fill_level;

    // Pending write moves the pointer on this edge
    assign write_pointer_next = write_pointer + address_width'(mem_write.enable);

    // Occupancy includes words still in the write pipeline
    // so only the beats behind the registered ready remain unseen
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            fill_level <= '0;
        end else begin
            fill_level <= write_pointer + address_width'(beat_valid)
                + address_width'(mem_write.enable) - read_pointer_synced;
        end
    end

    // Ready while below the threshold
    // Lags the level by one edge
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            rx_tready <= 1'b0;
        end else begin
            rx_tready <= (fill_level < address_width'(almost_full));
        end
    end

    // Capture stage for accepted beats
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= rx_tvalid && rx_tready;
        end
    end

    always_ff @(posedge rx_aclk) begin
        beat_data <= rx_tdata;
    end

    // Registered write toward storage
    // Address follows the pointer as it will be after this edge
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            mem_write <= '0;
        end else begin
            mem_write.enable <= beat_valid;
            mem_write.address <= write_pointer_next;
            mem_write.data <= beat_data;
        end
    end

    // Advances on the same edge that stores the word
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            write_pointer <= '0;
        end else begin
            write_pointer <= write_pointer_next;
        end
    end

    // Occupancy at acceptance leaves room for the two beats behind it
    assert property (@(posedge rx_aclk) disable iff (!rx_areset_n)
        rx_tvalid && rx_tready |-> fill_level <= address_width'(almost_full));

endmodule

`default_nettype wire

// ==== hdl/cdc_pointer_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_pointer_sync (
    // Domain that owns the pointer
    input wire source_aclk,
    input wire source_areset_n,
    input wire [cdc_fifo_cfg_pkg::address_width-1:0] source_pointer,
    // Domain that reads the pointer
    input wire dest_aclk,
    input wire dest_areset_n,
    output logic [cdc_fifo_cfg_pkg::address_width-1:0] dest_pointer
);
    import cdc_fifo_cfg_pkg::*;

    // Gray value launched from a flip-flop, never from logic
    logic [address_width-1:0] source_gray;
    // Destination flip-flop chain, stage 0 first
    logic [sync_stages-1:0][address_width-1:0] sync_chain;
    // Last stage of the chain
    logic [address_width-1:0] dest_gray;

    // Binary to gray
    // One bit flips per pointer step
    always_ff @(posedge source_aclk or negedge source_areset_n) begin
        if (!source_areset_n) begin
            source_gray <= '0;
        end else begin
            source_gray <= source_pointer ^ (source_pointer >> 1);
        end
    end

    // Shift the gray value through the chain
    always_ff @(posedge dest_aclk or negedge dest_areset_n) begin
        if (!dest_areset_n) begin
            sync_chain <= '0;
        end else begin
            sync_chain[0] <= source_gray;
            for (int i = 1; i < sync_stages; i++) begin
                sync_chain[i] <= sync_chain[i-1];
            end
        end
    end

    assign dest_gray = sync_chain[sync_stages-1];

    // Gray to binary
    // Each bit is the parity of itself and all higher gray bits
    always_comb begin
        for (int i = 0; i < address_width; i++) begin
            dest_pointer[i] = ^(dest_gray >> i);
        end
    end

    // Pointer steps by one at most, so the gray code moves one bit
    assert property (@(posedge source_aclk) disable iff (!source_areset_n)
        $countones(source_gray ^ $past(source_gray)) <= 1);

endmodule

`default_nettype wire

// ==== sim/cdc_fifo_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_checker (
    input wire rx_aclk,
    input wire rx_areset_n,
    input wire rx_tvalid,
    input wire rx_tready,
    input wire tx_aclk,
    input wire tx_areset_n,
    input wire tx_tvalid,
    input wire tx_tready,
    input wire [cdc_fifo_cfg_pkg::data_width-1:0] tx_tdata,
    // Current test as set by the testbench
    input wire [8*24-1:0] test_name,
    input wire [cdc_fifo_cfg_pkg::data_width-1:0] test_first,
    input wire [cdc_fifo_cfg_pkg::data_width-1:0] test_step,
    input int test_count,
    input wire test_begin,
    input wire test_end,
    input wire wait_failed,
    input wire fill_probe,
    output int pass_count,
    output int fail_count,
    output int loose_errors,
    output int outstanding
);
    import cdc_fifo_cfg_pkg::*;

    // Running totals since reset
    int accepted_total = 0;
    int delivered_total = 0;
    int rx_errors = 0;
    int tx_errors = 0;
    int passed = 0;
    int failed = 0;
    int attributed_errors = 0;
    // Snapshots taken when a test begins
    int delivered_base = 0;
    int error_base = 0;
    int accepted_in_test = 0;
    // Stall on the previous tx edge and the word shown then
    logic stalled = 1'b0;
    logic [data_width-1:0] held_data = '0;

    assign outstanding = accepted_total - delivered_total;
    assign loose_errors = rx_errors + tx_errors - attributed_errors;
    assign pass_count = passed;
    assign fail_count = failed;

    always @(posedge rx_aclk) begin
        int test_errors;
        int delivered_in_test;
        if (!rx_areset_n) begin
            if (rx_tready) begin
                $display("rx_tready is high during reset");
                rx_errors++;
            end
        end else begin
            if (test_begin) begin
                accepted_in_test = 0;
                delivered_base = delivered_total;
                error_base = rx_errors + tx_errors;
            end
            if (rx_tvalid && rx_tready) begin
                accepted_in_test++;
                accepted_total++;
            end
            // Full FIFO with the sink stalled
            if (fill_probe && accepted_in_test > fifo_depth) begin
                $display("%0s: fill stopped at %0d words, above the limit of %0d",
                    test_name, accepted_in_test, fifo_depth);
                rx_errors++;
            end
            if (test_end) begin
                delivered_in_test = delivered_total - delivered_base;
                if (delivered_in_test != accepted_in_test) begin
                    $display("FAILED %0s: delivered count expected %0d, actual %0d",
                        test_name, accepted_in_test, delivered_in_test);
                    rx_errors++;
                end
                if (accepted_in_test != test_count) begin
                    $display("FAILED %0s: accepted count expected %0d, actual %0d",
                        test_name, test_count, accepted_in_test);
                    rx_errors++;
                end
                test_errors = rx_errors + tx_errors - error_base;
                attributed_errors += test_errors;
                if (test_errors == 0 && !wait_failed) begin
                    passed++;
                    $display("pass  %0s: %0d words in order", test_name, accepted_in_test);
                end else begin
                    failed++;
                    $display("fail  %0s: %0d errors", test_name, test_errors);
                end
            end
        end
    end

    always @(posedge tx_aclk) begin
        int index;
        logic [data_width-1:0] expected_word;
        if (!tx_areset_n) begin
            stalled = 1'b0;
            if (tx_tvalid) begin
                $display("tx_tvalid is high during reset");
                tx_errors++;
            end
        end else begin
            // Word and valid must hold through a stall
            if (stalled && !tx_tvalid) begin
                $display("%0s: tx_tvalid dropped before the word was taken", test_name);
                tx_errors++;
            end else if (stalled && tx_tdata !== held_data) begin
                $display("FAILED %0s: held word expected %h, actual %h",
                    test_name, held_data, tx_tdata);
                tx_errors++;
            end
            if (tx_tvalid && tx_tready) begin
                // Word n of a test is first plus n steps
                index = delivered_total - delivered_base;
                expected_word = test_first + data_width'(index) * test_step;
                if (delivered_total >= accepted_total) begin
                    $display("%0s: word delivered on tx with none accepted on rx", test_name);
                    tx_errors++;
                end else if (tx_tdata !== expected_word) begin
                    $display("FAILED %0s: word %0d expected %h, actual %h",
                        test_name, index, expected_word, tx_tdata);
                    tx_errors++;
                end
                delivered_total++;
            end
            stalled = tx_tvalid && !tx_tready;
            held_data = tx_tdata;
        end
    end

endmodule

`default_nettype wire

// ==== sim/cdc_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_tb;
    import cdc_fifo_cfg_pkg::*;

    // Polling limits in rx cycles
    localparam int accept_limit = 64;
    localparam int drain_limit = 500;

    logic rx_aclk;
    logic rx_areset_n;
    logic rx_tvalid;
    logic [data_width-1:0] rx_tdata;
    logic rx_tready;
    logic tx_aclk;
    logic tx_areset_n;
    logic tx_tvalid;
    logic [data_width-1:0] tx_tdata;
    logic tx_tready;

    // Current test as handed to the checker
    logic [8*24-1:0] test_name;
    logic [data_width-1:0] test_first;
    logic [data_width-1:0] test_step;
    int test_count;
    logic test_begin;
    logic test_end;
    logic wait_failed;
    logic fill_probe;
    // Results from the checker
    int pass_count;
    int fail_count;
    int loose_errors;
    int outstanding;

    // Percent of tx cycles with tx_tready high
    int tx_percent;
    int setup_errors;

    cdc_fifo i_cdc_fifo (
        .rx_aclk(rx_aclk),
        .rx_areset_n(rx_areset_n),
        .rx_tvalid(rx_tvalid),
        .rx_tdata(rx_tdata),
        .rx_tready(rx_tready),
        .tx_aclk(tx_aclk),
        .tx_areset_n(tx_areset_n),
        .tx_tvalid(tx_tvalid),
        .tx_tdata(tx_tdata),
        .tx_tready(tx_tready)
    );

    cdc_fifo_checker i_checker (
        .rx_aclk(rx_aclk),
        .rx_areset_n(rx_areset_n),
        .rx_tvalid(rx_tvalid),
        .rx_tready(rx_tready),
        .tx_aclk(tx_aclk),
        .tx_areset_n(tx_areset_n),
        .tx_tvalid(tx_tvalid),
        .tx_tready(tx_tready),
        .tx_tdata(tx_tdata),
        .test_name(test_name),
        .test_first(test_first),
        .test_step(test_step),
        .test_count(test_count),
        .test_begin(test_begin),
        .test_end(test_end),
        .wait_failed(wait_failed),
        .fill_probe(fill_probe),
        .pass_count(pass_count),
        .fail_count(fail_count),
        .loose_errors(loose_errors),
        .outstanding(outstanding)
    );

    // Unrelated clocks of 100 ns and 70 ns
    always #50 rx_aclk = ~rx_aclk;
    always #35 tx_aclk = ~tx_aclk;

    // Random sink ready on the falling tx edge
    always @(negedge tx_aclk) begin
        tx_tready <= ($urandom % 100) < tx_percent;
    end

    // Feed one test's words into rx and then let the FIFO drain
    task automatic run_test(input logic [8*24-1:0] name, input int count,
            input logic [data_width-1:0] first, input logic [data_width-1:0] step,
            input int rx_pct, input int tx_pct);
        int sent;
        int idle;
        int waited;
        logic offer;
        logic failed;
        logic [data_width-1:0] word;
        sent = 0;
        idle = 0;
        failed = 1'b0;
        word = first;
        @(negedge rx_aclk);
        test_name = name;
        test_first = first;
        test_step = step;
        test_count = count;
        tx_percent = tx_pct;
        test_begin = 1'b1;
        @(negedge rx_aclk);
        test_begin = 1'b0;
        while (sent < count && !failed) begin
            fill_probe = 1'b0;
            offer = ($urandom % 100) < rx_pct;
            rx_tvalid = offer;
            rx_tdata = word;
            // Ready is stable here so this beat goes on the next rising edge
            if (offer && rx_tready) begin
                sent++;
                word = word + step;
                idle = 0;
            end else if (offer) begin
                idle++;
            end
            if (idle > accept_limit) begin
                if (tx_percent == 0) begin
                    // Full FIFO with the sink stalled
                    // Probe the level and then release the sink
                    fill_probe = 1'b1;
                    tx_percent = 100;
                    idle = 0;
                end else begin
                    $display("%0s: rx_tready stayed low for %0d cycles", name, accept_limit);
                    failed = 1'b1;
                end
            end
            @(negedge rx_aclk);
        end
        fill_probe = 1'b0;
        rx_tvalid = 1'b0;
        if (tx_percent == 0) begin
            $display("%0s: FIFO kept accepting while tx_tready was held low", name);
            failed = 1'b1;
            tx_percent = 100;
        end
        // Drain until every accepted word is out and tx_tvalid falls
        waited = 0;
        while ((outstanding != 0 || tx_tvalid) && waited < drain_limit) begin
            @(negedge rx_aclk);
            waited++;
        end
        if (outstanding != 0 || tx_tvalid) begin
            $display("%0s: FIFO did not drain within %0d rx cycles", name, drain_limit);
            failed = 1'b1;
        end
        wait_failed = failed;
        test_end = 1'b1;
        @(negedge rx_aclk);
        test_end = 1'b0;
        wait_failed = 1'b0;
    endtask

    initial begin
        int fd;
        int code;
        int count;
        int rx_pct;
        int tx_pct;
        string line;
        logic [8*24-1:0] name;
        logic [data_width-1:0] first;
        logic [data_width-1:0] step;
        rx_aclk = 1'b0;
        tx_aclk = 1'b0;
        rx_areset_n = 1'b0;
        tx_areset_n = 1'b0;
        rx_tvalid = 1'b0;
        rx_tdata = '0;
        tx_tready = 1'b0;
        tx_percent = 0;
        test_name = '0;
        test_first = '0;
        test_step = '0;
        test_count = 0;
        test_begin = 1'b0;
        test_end = 1'b0;
        wait_failed = 1'b0;
        fill_probe = 1'b0;
        setup_errors = 0;
        void'($urandom(79));
        // Each reset held for two cycles of its own clock
        fork
            begin
                repeat (2) @(posedge rx_aclk);
                @(negedge rx_aclk);
                rx_areset_n = 1'b1;
            end
            begin
                repeat (2) @(posedge tx_aclk);
                @(negedge tx_aclk);
                tx_areset_n = 1'b1;
            end
        join
        fd = $fopen("sim/cdc_fifo_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/cdc_fifo_testdata.txt");
            setup_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                // Skip blank and comment lines
                if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                code = $sscanf(line, "%s %d %h %h %d %d", name, count, first, step,
                    rx_pct, tx_pct);
                if (code != 6) begin
                    $display("malformed line in the data file: %s", line);
                    setup_errors++;
                end else begin
                    run_test(name, count, first, step, rx_pct, tx_pct);
                end
            end
            $fclose(fd);
        end
        $display("%0d tests passed, %0d tests failed, %0d errors outside tests",
            pass_count, fail_count, loose_errors + setup_errors);
        if (pass_count > 0 && fail_count == 0 && loose_errors == 0 && setup_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/cdc_fifo_testdata.txt ====
# One test per line: name, word count, first word (hex), step (hex),
# percent of rx cycles with rx_tvalid, percent of tx cycles with tx_tready
single_word 1 a5a5 0001 100 100
full_rate_short 8 0001 0001 100 100
full_rate_long 64 1000 0001 100 100
full_rate_step 40 0000 0111 100 100
wrap_value 30 fff0 0001 100 100
odd_step 33 1234 fedc 100 100
slow_source 24 2000 0002 20 100
slow_sink 48 3000 0003 100 20
sink_half 48 4000 0004 100 50
source_half 48 5000 0005 50 100
mixed_even 60 6000 0001 50 50
mixed_fast_rx 60 7000 0001 90 40
mixed_fast_tx 60 8000 0001 40 90
mixed_light 30 9000 0007 30 30
fill_full_rate 40 a000 0001 100 0
fill_mixed_rx 40 b000 0003 60 0
fill_slow_rx 40 c000 0005 30 0
after_fill 20 d000 0001 100 100
fill_again 40 e000 0010 100 0
burst_pair 2 0f0f 1010 100 100
burst_three 3 7fff 0001 100 100
long_mixed 120 0100 0009 70 60
long_sink_bound 120 0200 000b 100 30
mixed_alt 50 1357 2468 80 80
wrap_step 40 ff00 0100 100 70
near_full 16 aa00 0001 100 25
final_check 32 5555 1111 100 100
